//--- cpu_pkg.sv
package cpu_pkg;

  // fixed by the two-word instruction format
  localparam int prog_addr_w = 6;  // 64 program words
  localparam int data_addr_w = 6;  // 64 data words
  localparam int reg_idx_w = 4;  // 16 registers, low nibble of the reg byte
  localparam int word_w = 16;

  // uart bit time
  localparam int clks_per_bit = 8;
  localparam int bit_cnt_w = $clog2(clks_per_bit);

  // upper byte of the first word, anything else is a nop
  typedef enum logic [7:0] {
    op_jmp         = 8'h01,
    op_ram2reg     = 8'h02,
    op_reg2ram     = 8'h03,
    op_num2reg     = 8'h04,
    op_regminusnum = 8'h06,
    op_int         = 8'h0F
  } opcode_t;

  typedef enum logic [1:0] {
    fs_idle,    // waiting for start
    fs_first,   // first word on fetch_data
    fs_second,  // second word on fetch_data
    fs_hold     // full instr buffered, exec slot busy
  } fetch_state_t;

  typedef enum logic [1:0] {
    us_idle,
    us_start,
    us_data,
    us_stop
  } uart_state_t;

  // program load port
  typedef struct packed {
    logic                   we;
    logic [prog_addr_w-1:0] addr;
    logic [word_w-1:0]      data;
  } prog_load_t;

  typedef struct packed {
    opcode_t                op;
    logic [reg_idx_w-1:0]   rd;
    logic [word_w-1:0]      operand;  // address or value
    logic [prog_addr_w-1:0] pc;       // addr of the first word
  } decoded_instr_t;

  typedef struct packed {
    logic                   taken;
    logic [prog_addr_w-1:0] target;
  } jump_t;

  typedef struct packed {
    logic                   valid;
    logic [data_addr_w-1:0] addr;
    logic [word_w-1:0]      data;
  } store_t;

endpackage

//--- program_ram.sv
`timescale 1ns/1ps

module program_ram (
  input  logic                             clk,
  input  cpu_pkg::prog_load_t              prog_load,
  input  logic [cpu_pkg::prog_addr_w-1:0]  fetch_addr,
  output logic [cpu_pkg::word_w-1:0]       fetch_data
);
  import cpu_pkg::*;

  logic [word_w-1:0] mem [2**prog_addr_w];  // 64 x 16 program store

  // load port, only used while the core sits in reset or idle
  always_ff @(posedge clk) begin
    if (prog_load.we) begin
      mem[prog_load.addr] <= prog_load.data;
    end
  end

  // registered fetch read
  // data for an address shows up one clock later
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

//--- instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  output logic [cpu_pkg::prog_addr_w-1:0]  fetch_addr,
  input  logic [cpu_pkg::word_w-1:0]       fetch_data,
  input  cpu_pkg::jump_t                   jump,
  output cpu_pkg::decoded_instr_t          instr,
  output logic                             instr_valid,
  input  logic                             exec_ready
);
  import cpu_pkg::*;

  fetch_state_t           state;
  logic [prog_addr_w-1:0] pc;           // next word address to fetch
  logic [prog_addr_w-1:0] word_pc;      // first word addr of instr in flight
  logic [word_w-1:0]      first_word;   // opcode + reg byte
  logic [word_w-1:0]      second_word;  // operand, kept while the slot is busy
  logic                   slot_free;
  logic                   load_instr;
  logic                   issue;        // first word address goes out this cycle
  decoded_instr_t         next_instr;

  // output slot empties when not valid or consumed now
  assign slot_free = !instr_valid || exec_ready;

  assign load_instr = !jump.taken && slot_free &&
                      (state == fs_second || state == fs_hold);

  assign issue = jump.taken || (state == fs_idle && start) || load_instr;

  // redirect goes straight to the ram, no bubble
  assign fetch_addr = jump.taken ? jump.target : pc;

  always_comb begin
    next_instr.op      = opcode_t'(first_word[15:8]);  // unknown values act as nop
    next_instr.rd      = first_word[reg_idx_w-1:0];
    next_instr.operand = (state == fs_hold) ? second_word : fetch_data;
    next_instr.pc      = word_pc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= fs_idle;
      pc          <= '0;  // start always fetches from 0
      instr_valid <= 1'b0;
    end else begin
      if (issue) begin
        pc    <= fetch_addr + 1'b1;
        state <= fs_first;
      end else if (state == fs_first) begin
        pc    <= pc + 1'b1;  // second word addr is out now
        state <= fs_second;
      end else if (state == fs_second) begin
        state <= fs_hold;  // exec still busy, park word 2
      end

      // jump flushes the held instr
      if (jump.taken) begin
        instr_valid <= 1'b0;
      end else if (load_instr) begin
        instr_valid <= 1'b1;
      end else if (exec_ready) begin
        instr_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) word_pc <= fetch_addr;
    if (state == fs_first) first_word <= fetch_data;
    if (state == fs_second) second_word <= fetch_data;
    if (load_instr) instr <= next_instr;  // stable until consumed
  end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_pkg::decoded_instr_t instr,
  input  logic                    instr_valid,
  output logic                    exec_ready,
  output cpu_pkg::jump_t          jump,
  output cpu_pkg::store_t         store,
  output logic [7:0]              tx_byte,
  output logic                    tx_start,
  input  logic                    tx_ready
);
  import cpu_pkg::*;

  logic [word_w-1:0]      regs [2**reg_idx_w];    // register file
  logic [word_w-1:0]      dmem [2**data_addr_w];  // data memory
  logic                   fire;                   // instr consumed this cycle
  logic [word_w-1:0]      rd_val;
  logic [data_addr_w-1:0] mem_addr;

  assign rd_val   = regs[instr.rd];
  assign mem_addr = instr.operand[data_addr_w-1:0];

  // only int can stall, and only on a busy transmitter
  assign exec_ready = !(instr_valid && instr.op == op_int && !tx_ready);
  assign fire       = instr_valid && exec_ready;

  // redirect is combinational so the decoder drops the next instr in time
  assign jump = '{
    taken:  fire && instr.op == op_jmp,
    target: {instr.operand[prog_addr_w-1:1], 1'b0}  // forced even
  };

  // tx_ready already high whenever this fires
  assign tx_start = fire && instr.op == op_int;
  assign tx_byte  = rd_val[7:0];  // low byte only

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_idx_w; i++) begin
        regs[i] <= '0;
      end
      for (int j = 0; j < 2**data_addr_w; j++) begin
        dmem[j] <= '0;
      end
      store <= '0;
    end else begin
      // one-cycle store event, a clock after consume
      store.valid <= fire && instr.op == op_reg2ram;
      store.addr  <= mem_addr;
      store.data  <= rd_val;

      if (fire) begin
        case (instr.op)
          op_num2reg: begin
            regs[instr.rd] <= instr.operand;
          end
          op_regminusnum: begin
            regs[instr.rd] <= rd_val - instr.operand;  // wraps mod 2^16
          end
          op_ram2reg: begin
            regs[instr.rd] <= dmem[mem_addr];
          end
          op_reg2ram: begin
            dmem[mem_addr] <= rd_val;
          end
          default: begin
            // jmp and int act through the comb outputs, rest is nop
          end
        endcase
      end
    end
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

// 8N1 serializer, lsb first
module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       tx
);
  import cpu_pkg::*;

  uart_state_t          state;
  logic [bit_cnt_w-1:0] tick_cnt;  // clocks spent in the current bit
  logic [2:0]           bit_idx;   // data bit being sent
  logic [7:0]           shifter;
  logic                 bit_done;

  assign bit_done = tick_cnt == bit_cnt_w'(clks_per_bit - 1);
  assign tx_ready = state == us_idle;  // low for the whole frame

  always_comb begin
    case (state)
      us_start: tx = 1'b0;
      us_data:  tx = shifter[0];
      default:  tx = 1'b1;  // idle and stop are mark
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= us_idle;
      tick_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      tick_cnt <= (state == us_idle || bit_done) ? '0 : tick_cnt + 1'b1;
      case (state)
        us_idle: if (tx_start) state <= us_start;
        us_start: begin
          if (bit_done) begin
            state   <= us_data;
            bit_idx <= '0;
          end
        end
        us_data: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) state <= us_stop;
            bit_idx <= bit_idx + 1'b1;
          end
        end
        us_stop: if (bit_done) state <= us_idle;
        default: state <= us_idle;
      endcase
    end
  end

  // byte latched on start, shifted out after each data bit
  always_ff @(posedge clk) begin
    if (tx_ready && tx_start) begin
      shifter <= tx_byte;
    end else if (state == us_data && bit_done) begin
      shifter <= shifter >> 1;
    end
  end

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  cpu_pkg::prog_load_t prog_load,
  output cpu_pkg::store_t     store,
  output logic                tx
);
  import cpu_pkg::*;

  logic [prog_addr_w-1:0] fetch_addr;
  logic [word_w-1:0]      fetch_data;
  decoded_instr_t         instr;
  logic                   instr_valid;
  logic                   exec_ready;   // back-pressure into fetch
  jump_t                  jump;
  logic [7:0]             tx_byte;
  logic                   tx_start;
  logic                   tx_ready;

  program_ram u_program_ram (
    .clk        (clk),
    .prog_load  (prog_load),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data)
  );

  instr_decode u_instr_decode (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .jump        (jump),
    .instr       (instr),
    .instr_valid (instr_valid),
    .exec_ready  (exec_ready)
  );

  exec_unit u_exec_unit (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .exec_ready  (exec_ready),
    .jump        (jump),
    .store       (store),
    .tx_byte     (tx_byte),
    .tx_start    (tx_start),
    .tx_ready    (tx_ready)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

endmodule

//--- cpu_core_sva.sv
`timescale 1ns/1ps

// control checks on the execute stage bound into exec_unit
module cpu_core_sva (
  input logic clk,
  input logic reset,
  input logic tx_start,
  input logic tx_ready,
  input logic store_valid,
  input logic jump_taken
);
  int fail_cnt = 0;  // assertion failure tally

  // uart only takes a byte when idle and goes busy on it
  a_start_ready: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> tx_ready ##1 !tx_ready)
    else begin
      fail_cnt++;
      $error("tx_start was not taken by an idle transmitter");
    end

  a_store_pulse: assert property (@(posedge clk) disable iff (reset) store_valid |=> !store_valid)
    else begin
      fail_cnt++;
      $error("store.valid held for more than one cycle");
    end

  a_jump_pulse: assert property (@(posedge clk) disable iff (reset) jump_taken |=> !jump_taken)
    else begin
      fail_cnt++;
      $error("jump.taken held for more than one cycle");
    end

  // nothing fires right out of reset
  a_quiet_after_reset: assert property (@(posedge clk)
    reset |=> !(store_valid || jump_taken || tx_start))
    else begin
      fail_cnt++;
      $error("control output active in the cycle after reset");
    end

endmodule

bind exec_unit cpu_core_sva u_exec_sva (
  .clk         (clk),
  .reset       (reset),
  .tx_start    (tx_start),
  .tx_ready    (tx_ready),
  .store_valid (store.valid),
  .jump_taken  (jump.taken)
);

//--- cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
  import cpu_pkg::*;

  localparam int n_instr = 20;  // two words each
  localparam int margin  = 400;  // slack cycles on top of the run estimate

  logic              clk;
  logic              reset;
  logic              start;
  prog_load_t        prog_load;
  store_t            store;
  logic              tx;
  logic [31:0]       lfsr = 32'ha55356ac;
  logic [word_w-1:0] prog [2**prog_addr_w];  // image loaded into the core
  store_t            exp_store [$];
  logic [7:0]        exp_byte [$];
  int                cycle_cnt = 0;
  int                limit = 1000;  // covers reset, load and idle window

  cpu_core u_dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .prog_load (prog_load),
    .store     (store),
    .tx        (tx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_store(input store_t got, input store_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch store: got addr=%h data=%h, expected addr=%h data=%h",
                         got.addr, got.data, exp.addr, exp.data));
    end
  endtask

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) fail_run($sformatf("mismatch tx byte: got %h expected %h", got, exp));
  endtask

  task automatic build_program();
    logic [2:0]        pick;
    logic [7:0]        op;
    logic [7:0]        reg_byte;
    logic [word_w-1:0] operand;
    int                k;
    for (int a = 0; a < 2**prog_addr_w; a++) begin
      prog[a] = {10'h000, 6'(a)};  // nop filler tagged with its address
    end
    for (int i = 0; i < n_instr; i++) begin
      pick     = 3'(rand_bits(3));
      reg_byte = 8'(rand_bits(8)) & 8'hF3;  // regs 0..3 with junk upper nibble
      operand  = 16'(rand_bits(16));
      case (pick)
        3'd0, 3'd1: op = op_num2reg;
        3'd2:       op = op_regminusnum;
        3'd3:       op = op_ram2reg;
        3'd4, 3'd5: op = op_reg2ram;
        3'd6:       op = op_int;
        default:    op = op_jmp;
      endcase
      // only 8 data addrs for more reuse
      if (op == op_ram2reg || op == op_reg2ram) operand[5:3] = 3'b000;
      if (i == n_instr - 1) begin
        op = op_jmp;
        k  = i;  // final spin on itself
      end else begin
        k = i + 1 + int'(rand_bits(2));  // always forward
        if (k > n_instr - 1) k = n_instr - 1;
      end
      if (op == op_jmp) operand[5:0] = {5'(k), operand[0]};  // odd bit must be dropped
      prog[2*i]     = {op, reg_byte};
      prog[2*i + 1] = operand;
    end
  endtask

  // walks the program the way the core should and fills both queues
  task automatic run_model(output int n_exec, output int n_int);
    logic [word_w-1:0]      regs [2**reg_idx_w] = '{default: '0};
    logic [word_w-1:0]      dmem [2**data_addr_w] = '{default: '0};
    logic [prog_addr_w-1:0] pc = '0;
    logic [prog_addr_w-1:0] target;
    logic [7:0]             op;
    logic [reg_idx_w-1:0]   rd;
    logic [word_w-1:0]      opnd;
    logic                   done = 1'b0;
    n_exec = 0;
    n_int  = 0;
    while (!done) begin
      op     = prog[pc][15:8];
      rd     = prog[pc][reg_idx_w-1:0];
      opnd   = prog[pc + 1'b1];
      target = {opnd[prog_addr_w-1:1], 1'b0};
      n_exec++;
      case (op)
        op_num2reg:     regs[rd] = opnd;
        op_regminusnum: regs[rd] = regs[rd] - opnd;  // 16-bit wrap
        op_ram2reg:     regs[rd] = dmem[opnd[data_addr_w-1:0]];
        op_reg2ram: begin
          dmem[opnd[data_addr_w-1:0]] = regs[rd];
          exp_store.push_back(store_t'{1'b1, opnd[data_addr_w-1:0], regs[rd]});
        end
        op_int: begin
          exp_byte.push_back(regs[rd][7:0]);
          n_int++;
        end
        default: ;
      endcase
      done = (op == op_jmp) && (target == pc);
      pc   = (op == op_jmp) ? target : pc + 2'd2;
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit) fail_run("timeout, program results did not all arrive");
  end

  // store monitor
  always @(negedge clk) begin
    if (!reset && store.valid === 1'b1) begin
      if (exp_store.size() == 0) fail_run("store event appeared with no store left to expect");
      else compare_store(store, exp_store.pop_front());
    end
  end

  // 8N1 receiver sampling mid bit
  initial begin
    logic [7:0] rx;
    wait (reset === 1'b0);
    forever begin
      @(negedge tx);
      repeat (clks_per_bit / 2) @(negedge clk);
      if (tx !== 1'b0) fail_run("start bit on tx did not stay low");
      for (int b = 0; b < 8; b++) begin
        repeat (clks_per_bit) @(negedge clk);
        rx[b] = tx;  // lsb first
      end
      repeat (clks_per_bit) @(negedge clk);
      if (tx !== 1'b1) fail_run("stop bit on tx was not high");
      if (exp_byte.size() == 0) fail_run("byte received on tx with no print left to expect");
      else compare_byte(rx, exp_byte.pop_front());
    end
  end

  initial begin
    int n_exec;
    int n_int;
    reset     = 1'b1;
    start     = 1'b0;
    prog_load = '0;
    build_program();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int a = 0; a < 2**prog_addr_w; a++) begin
      prog_load = '{we: 1'b1, addr: prog_addr_w'(a), data: prog[a]};
      @(negedge clk);
    end
    prog_load = '0;
    // idle with no start so tx and the monitors must stay quiet
    for (int c = 0; c < 40; c++) begin
      @(negedge clk);
      if (tx !== 1'b1) fail_run("tx left the idle high level before start");
    end
    run_model(n_exec, n_int);
    limit = cycle_cnt + n_exec * 10 + n_int * 10 * clks_per_bit + margin;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (exp_store.size() != 0 || exp_byte.size() != 0) @(negedge clk);
    repeat (20 * clks_per_bit) @(negedge clk);  // room for any stray result
    if (u_dut.u_exec_unit.u_exec_sva.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run($sformatf("%0d concurrent assertion failures in exec_unit",
                         u_dut.u_exec_unit.u_exec_sva.fail_cnt));
    end
  end

endmodule

//--- cpu_core.f
cpu_pkg.sv
program_ram.sv
instr_decode.sv
exec_unit.sv
uart_tx.sv
cpu_core.sv
cpu_core_sva.sv
cpu_core_tb.sv
